// ==== sim/textCases.mem ====
// Columns: kind test w2 w3 w4 w5 w6 w7, all hex, kind 0 ends the list
// Kind 1 is a write (address data), kind 2 a pixel (x y blank red green blue)
// Test 1 display still disabled after reset
2 01 0000 0000 0 00 00 00
2 01 0008 0000 0 00 00 00
2 01 0064 00C8 0 00 00 00
// Test 2 foreground, glyph 41 row 0 is 10100101, cells 0 to 4 of row 0
1 02 2000 0001 0 00 00 00
1 02 1410 00A5 0 00 00 00
1 02 0000 0941 0 00 00 00
1 02 0001 2741 0 00 00 00
1 02 0002 5E41 0 00 00 00
1 02 0003 F341 0 00 00 00
1 02 0004 6F41 0 00 00 00
2 02 0000 0000 0 1F 00 00
2 02 0007 0000 0 1F 00 00
2 02 000A 0000 0 08 10 08
2 02 0015 0000 0 00 3F 1F
2 02 0018 0000 0 0F 1F 00
2 02 0027 0000 0 1F 3F 1F
// Test 3 background at the clear bits of the same row
2 03 0001 0000 0 00 00 00
2 03 000B 0000 0 00 3F 00
2 03 0014 0000 0 1F 00 1F
2 03 001E 0000 0 1F 3F 1F
2 03 0021 0000 0 00 3F 1F
// Test 4 rows, columns, glyph rows and a code above 7F
1 04 1415 000F 0 00 00 00
1 04 1020 0080 0 00 00 00
1 04 102F 0001 0 00 00 00
1 04 00CA 1C41 0 00 00 00
1 04 07FF 3D82 0 00 00 00
2 04 0056 0035 0 00 00 1F
2 04 0051 0035 0 1F 00 00
2 04 0050 0030 0 00 00 1F
2 04 01F8 01F0 0 1F 00 1F
2 04 01F9 01F0 0 1F 3F 00
2 04 01FF 01FF 0 1F 00 1F
2 04 01F8 01FF 0 1F 3F 00
// Test 5 blank input, off-grid cursors, then display disabled
1 05 2001 0000 0 00 00 00
2 05 0000 0000 0 1F 00 00
2 05 0000 0000 1 00 00 00
2 05 000A 0000 1 00 00 00
2 05 0200 0000 0 00 00 00
2 05 0000 0200 0 00 00 00
2 05 03FF 03FF 0 00 00 00
1 05 2000 0000 0 00 00 00
2 05 0000 0000 0 00 00 00
2 05 0056 0035 0 00 00 00
// Test 6 back-to-back pixels across cell 1 and other cells
1 06 2000 0001 0 00 00 00
2 06 0008 0000 0 08 10 08
2 06 0009 0000 0 00 3F 00
2 06 000A 0000 0 08 10 08
2 06 000B 0000 0 00 3F 00
2 06 000C 0000 0 00 3F 00
2 06 000D 0000 0 08 10 08
2 06 000E 0000 0 00 3F 00
2 06 000F 0000 0 08 10 08
2 06 0056 0035 0 00 00 1F
2 06 01F9 01F0 0 1F 3F 00

// ==== files.f ====
common/ppuPkg.sv
textRender/dualPortRam.sv
textRender/textPipeline.sv
source/hostWriteDecoder.sv
source/colorPalette.sv
source/ppuTop.sv
sim/ppuTop_props.sv
sim/ppuChecker.sv
sim/ppuTb.sv

// ==== sim/ppuTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppuTb;

    localparam int caseWidth = 8;  // Words per line of the case file
    localparam int maxCases  = 128;
    localparam int latency   = ppuPkg::pipeLatency;

    logic                           clk;
    logic                           reset;
    logic                           wen;
    logic [15:0]                    address;
    logic [15:0]                    data;
    logic [ppuPkg::cursorWidth-1:0] xCursor;
    logic [ppuPkg::cursorWidth-1:0] yCursor;
    logic                           blank;
    logic [4:0]                     rgbRed;
    logic [5:0]                     rgbGreen;
    logic [4:0]                     rgbBlue;

    logic                           expValid;
    logic [7:0]                     expTest;
    logic [4:0]                     expRed;
    logic [5:0]                     expGreen;
    logic [4:0]                     expBlue;
    logic                           flush;
    int                             checkCount;
    int                             errorCount;
    int                             testCount;
    int                             failedTests;

    logic [15:0]                    caseWords [caseWidth*maxCases];
    int                             caseCount;
    int                             pixelCount;
    int                             timeoutLimit;
    logic                           loaded;

    ppuTop ppuTop_inst (
        .clk     (clk),
        .reset   (reset),
        .wen     (wen),
        .address (address),
        .data    (data),
        .xCursor (xCursor),
        .yCursor (yCursor),
        .blank   (blank),
        .rgbRed  (rgbRed),
        .rgbGreen(rgbGreen),
        .rgbBlue (rgbBlue)
    );

    ppuChecker #(
        .latency(latency)
    ) ppuChecker_inst (
        .clk        (clk),
        .reset      (reset),
        .expValid   (expValid),
        .expTest    (expTest),
        .expRed     (expRed),
        .expGreen   (expGreen),
        .expBlue    (expBlue),
        .rgbRed     (rgbRed),
        .rgbGreen   (rgbGreen),
        .rgbBlue    (rgbBlue),
        .flush      (flush),
        .checkCount (checkCount),
        .errorCount (errorCount),
        .testCount  (testCount),
        .failedTests(failedTests)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic idleCycle();
        wen      <= 1'b0;
        blank    <= 1'b1;
        expValid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic applyWrite(input int base);
        wen      <= 1'b1;
        address  <= caseWords[base+2];
        data     <= caseWords[base+3];
        blank    <= 1'b1;
        expValid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic applyPixel(input int base);
        wen      <= 1'b0;
        xCursor  <= caseWords[base+2][ppuPkg::cursorWidth-1:0];
        yCursor  <= caseWords[base+3][ppuPkg::cursorWidth-1:0];
        blank    <= caseWords[base+4][0];
        expValid <= 1'b1;
        expTest  <= caseWords[base+1][7:0];
        expRed   <= caseWords[base+5][4:0];
        expGreen <= caseWords[base+6][5:0];
        expBlue  <= caseWords[base+7][4:0];
        @(posedge clk);
    endtask

    initial begin
        int kind;
        int prevKind;
        reset      = 1'b0;
        wen        = 1'b0;
        address    = '0;
        data       = '0;
        xCursor    = '0;
        yCursor    = '0;
        blank      = 1'b1;
        expValid   = 1'b0;
        expTest    = '0;
        expRed     = '0;
        expGreen   = '0;
        expBlue    = '0;
        flush      = 1'b0;
        loaded     = 1'b0;
        caseCount  = 0;
        pixelCount = 0;
        for (int i = 0; i < caseWidth * maxCases; i++) begin
            caseWords[i] = '0;
        end
        $readmemh("sim/textCases.mem", caseWords);
        while ((caseCount < maxCases) && (caseWords[caseCount*caseWidth] != 16'd0)) begin
            caseCount++;
        end
        timeoutLimit = 4 * caseCount + 100;
        loaded       = 1'b1;

        repeat (8) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);

        prevKind = 0;
        for (int n = 0; n < caseCount; n++) begin
            kind = caseWords[n*caseWidth];
            if ((kind != 1) && (prevKind == 1)) begin
                repeat (2) idleCycle();  // Let the memories take the writes
            end else if ((kind == 1) && (prevKind == 2)) begin
                repeat (latency) idleCycle();  // Drain pixels in flight
            end
            if (kind == 1) begin
                applyWrite(n * caseWidth);
            end else begin
                applyPixel(n * caseWidth);
                pixelCount++;
            end
            prevKind = kind;
        end

        repeat (latency + 1) idleCycle();
        flush <= 1'b1;
        repeat (2) @(posedge clk);

        if (caseCount == 0) begin
            $display("No cases were read from sim/textCases.mem");
        end
        if (checkCount != pixelCount) begin
            $display("Checker compared %0d pixels but %0d were driven", checkCount, pixelCount);
        end
        $display("tests %0d, failed %0d, pixel checks %0d of %0d, value errors %0d",
                 testCount, failedTests, checkCount, pixelCount, errorCount);
        if ((caseCount == 0) || (checkCount != pixelCount) || (errorCount != 0) ||
            (failedTests != 0)) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

    // Cycle limit scales with the number of cases
    initial begin
        int cycles;
        cycles = 0;
        wait (loaded);
        while (cycles < timeoutLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", timeoutLimit);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/ppuChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppuChecker #(
    parameter int latency = 3
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       expValid,
    input  logic [7:0] expTest,
    input  logic [4:0] expRed,
    input  logic [5:0] expGreen,
    input  logic [4:0] expBlue,
    input  logic [4:0] rgbRed,
    input  logic [5:0] rgbGreen,
    input  logic [4:0] rgbBlue,
    input  logic       flush,
    output int         checkCount,
    output int         errorCount,
    output int         testCount,
    output int         failedTests
);

    // Entries packed as {test, red, green, blue}
    logic        validPipe [latency];
    logic [23:0] expPipe   [latency];

    logic [7:0]  currentTest;
    logic        testOpen;
    int          testChecks;
    int          testErrors;

    task automatic compareField(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic closeTest();
        testCount++;
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("test %0d %s: %0d pixels checked, %0d errors", currentTest,
                 (testErrors == 0) ? "passed" : "failed", testChecks, testErrors);
        testOpen = 1'b0;
    endtask

    task automatic checkPixel(input logic [23:0] entry);
        logic [7:0] test;
        test = entry[23:16];
        if (testOpen && (test != currentTest)) begin
            closeTest();
        end
        if (!testOpen) begin
            currentTest = test;
            testChecks  = 0;
            testErrors  = 0;
            testOpen    = 1'b1;
        end
        checkCount++;
        testChecks++;
        compareField("rgbRed", {3'b000, entry[15:11]}, {3'b000, rgbRed});
        compareField("rgbGreen", {2'b00, entry[10:5]}, {2'b00, rgbGreen});
        compareField("rgbBlue", {3'b000, entry[4:0]}, {3'b000, rgbBlue});
    endtask

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < latency; i++) begin
                validPipe[i] <= 1'b0;
            end
            checkCount  = 0;
            errorCount  = 0;
            testCount   = 0;
            failedTests = 0;
            testOpen    = 1'b0;
        end else begin
            validPipe[0] <= expValid;
            expPipe[0]   <= {expTest, expRed, expGreen, expBlue};
            for (int i = 1; i < latency; i++) begin
                validPipe[i] <= validPipe[i-1];
                expPipe[i]   <= expPipe[i-1];
            end
            if (validPipe[latency-1]) begin
                checkPixel(expPipe[latency-1]);  // Cursor driven three edges ago
            end
            if (flush && testOpen) begin
                closeTest();
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/ppuTop_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppuTopProps (
    input logic       clk,
    input logic       reset,
    input logic       wen,
    input logic       blank,
    input logic       cellWrite,
    input logic       glyphWrite,
    input logic       displayEnable,
    input logic [4:0] rgbRed,
    input logic [5:0] rgbGreen,
    input logic [4:0] rgbBlue
);

    logic rgbZero;

    assign rgbZero = (rgbRed == 5'd0) && (rgbGreen == 6'd0) && (rgbBlue == 5'd0);

    blankGivesBlack: assert property (@(posedge clk) disable iff (!reset)
        blank |-> ##3 rgbZero)
        else $error("RGB not black three clocks after blank was high");

    // Memory strobes come only from a registered host write
    writeFollowsWen: assert property (@(posedge clk) disable iff (!reset)
        (cellWrite || glyphWrite) |-> $past(wen))
        else $error("Memory write strobe without a host write the clock before");

    disabledIsBlack: assert property (@(posedge clk) disable iff (!reset)
        !displayEnable |=> rgbZero)
        else $error("RGB not black while the display is disabled");

endmodule

bind ppuTop ppuTopProps ppuTopProps_inst (
    .clk          (clk),
    .reset        (reset),
    .wen          (wen),
    .blank        (blank),
    .cellWrite    (cellWrite),
    .glyphWrite   (glyphWrite),
    .displayEnable(displayEnable),
    .rgbRed       (rgbRed),
    .rgbGreen     (rgbGreen),
    .rgbBlue      (rgbBlue)
);

`default_nettype wire

// ==== source/ppuTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module ppuTop #(
    parameter int cursorWidth    = ppuPkg::cursorWidth,
    parameter int cellAddrWidth  = ppuPkg::cellAddrWidth,
    parameter int glyphAddrWidth = ppuPkg::glyphAddrWidth
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wen,
    input  logic [15:0]            address,
    input  logic [15:0]            data,
    input  logic [cursorWidth-1:0] xCursor,
    input  logic [cursorWidth-1:0] yCursor,
    input  logic                   blank,
    output logic [4:0]             rgbRed,
    output logic [5:0]             rgbGreen,
    output logic [4:0]             rgbBlue
);

    logic                      cellWrite;
    logic [cellAddrWidth-1:0]  cellWriteAddr;
    logic [15:0]               cellWriteData;
    logic [cellAddrWidth-1:0]  cellReadAddr;
    logic [15:0]               cellReadData;
    logic                      glyphWrite;
    logic [glyphAddrWidth-1:0] glyphWriteAddr;
    logic [7:0]                glyphWriteData;
    logic [glyphAddrWidth-1:0] glyphReadAddr;
    logic [7:0]                glyphReadData;
    logic                      displayEnable;
    logic [7:0]                attribute;
    logic                      pixelOn;
    logic                      pixelBlank;

    hostWriteDecoder #(
        .cellAddrWidth (cellAddrWidth),
        .glyphAddrWidth(glyphAddrWidth)
    ) hostWriteDecoder_inst (
        .clk          (clk),
        .reset        (reset),
        .wen          (wen),
        .address      (address),
        .data         (data),
        .cellWrite    (cellWrite),
        .cellAddr     (cellWriteAddr),
        .cellData     (cellWriteData),
        .glyphWrite   (glyphWrite),
        .glyphAddr    (glyphWriteAddr),
        .glyphData    (glyphWriteData),
        .displayEnable(displayEnable)
    );

    dualPortRam #(
        .dataWidth(16),
        .addrWidth(cellAddrWidth)
    ) cellRam (
        .clk        (clk),
        .writeEnable(cellWrite),
        .writeAddr  (cellWriteAddr),
        .writeData  (cellWriteData),
        .readAddr   (cellReadAddr),
        .readData   (cellReadData)
    );

    dualPortRam #(
        .dataWidth(8),
        .addrWidth(glyphAddrWidth)
    ) glyphRam (
        .clk        (clk),
        .writeEnable(glyphWrite),
        .writeAddr  (glyphWriteAddr),
        .writeData  (glyphWriteData),
        .readAddr   (glyphReadAddr),
        .readData   (glyphReadData)
    );

    textPipeline #(
        .cursorWidth   (cursorWidth),
        .cellAddrWidth (cellAddrWidth),
        .glyphAddrWidth(glyphAddrWidth)
    ) textPipeline_inst (
        .clk          (clk),
        .reset        (reset),
        .xCursor      (xCursor),
        .yCursor      (yCursor),
        .blank        (blank),
        .cellData     (cellReadData),
        .glyphData    (glyphReadData),
        .cellReadAddr (cellReadAddr),
        .glyphReadAddr(glyphReadAddr),
        .attribute    (attribute),
        .pixelOn      (pixelOn),
        .pixelBlank   (pixelBlank)
    );

    colorPalette colorPalette_inst (
        .clk          (clk),
        .reset        (reset),
        .attribute    (attribute),
        .pixelOn      (pixelOn),
        .pixelBlank   (pixelBlank),
        .displayEnable(displayEnable),
        .rgbRed       (rgbRed),
        .rgbGreen     (rgbGreen),
        .rgbBlue      (rgbBlue)
    );

endmodule

`default_nettype wire

// ==== source/colorPalette.sv ====
`timescale 1ns/100ps
`default_nettype none

module colorPalette (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] attribute,
    input  logic       pixelOn,
    input  logic       pixelBlank,
    input  logic       displayEnable,
    output logic [4:0] rgbRed,
    output logic [5:0] rgbGreen,
    output logic [4:0] rgbBlue
);

    ppuPkg::fgColor fgIndex;
    logic [2:0]     bgIndex;
    logic [23:0]    color;
    logic           showPixel;

    assign fgIndex = ppuPkg::fgColor'(attribute[3:0]);
    assign bgIndex = attribute[6:4];  // Bit 7 is unused

    always_comb begin
        if (pixelOn) begin
            color = ppuPkg::fgPalette[fgIndex];
        end else begin
            color = ppuPkg::bgPalette[bgIndex];
        end
    end

    assign showPixel = displayEnable && !pixelBlank;

    // Third pipeline stage
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rgbRed   <= '0;
            rgbGreen <= '0;
            rgbBlue  <= '0;
        end else if (showPixel) begin
            rgbRed   <= color[23:19];  // Upper 5 bits of red
            rgbGreen <= color[15:10];  // Upper 6 bits of green
            rgbBlue  <= color[7:3];
        end else begin
            rgbRed   <= '0;
            rgbGreen <= '0;
            rgbBlue  <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/hostWriteDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module hostWriteDecoder #(
    parameter int cellAddrWidth  = 11,
    parameter int glyphAddrWidth = 11
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wen,
    input  logic [15:0]               address,
    input  logic [15:0]               data,
    output logic                      cellWrite,
    output logic [cellAddrWidth-1:0]  cellAddr,
    output logic [15:0]               cellData,
    output logic                      glyphWrite,
    output logic [glyphAddrWidth-1:0] glyphAddr,
    output logic [7:0]                glyphData,
    output logic                      displayEnable
);

    localparam int cellEntries  = 1 << cellAddrWidth;
    localparam int glyphEntries = 1 << glyphAddrWidth;

    logic [15:0]       cellOffset;
    logic [15:0]       glyphOffset;
    ppuPkg::regionKind region;

    assign cellOffset  = address - ppuPkg::cellRegionBase;
    assign glyphOffset = address - ppuPkg::glyphRegionBase;

    always_comb begin
        region = ppuPkg::regionNone;  // Unmapped writes fall through
        if (address == ppuPkg::controlAddr) begin
            region = ppuPkg::regionControl;
        end else if (cellOffset < cellEntries) begin
            region = ppuPkg::regionCell;
        end else if (glyphOffset < glyphEntries) begin
            region = ppuPkg::regionGlyph;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cellWrite     <= 1'b0;
            glyphWrite    <= 1'b0;
            displayEnable <= 1'b0;
        end else begin
            cellWrite  <= wen && (region == ppuPkg::regionCell);
            glyphWrite <= wen && (region == ppuPkg::regionGlyph);
            if (wen && (region == ppuPkg::regionControl)) begin
                displayEnable <= data[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            cellAddr  <= cellOffset[cellAddrWidth-1:0];
            cellData  <= data;  // Attribute high, code low
            glyphAddr <= glyphOffset[glyphAddrWidth-1:0];
            glyphData <= data[7:0];  // One glyph row
        end
    end

endmodule

`default_nettype wire

// ==== textRender/textPipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module textPipeline #(
    parameter int cursorWidth    = 10,
    parameter int cellAddrWidth  = 11,
    parameter int glyphAddrWidth = 11
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [cursorWidth-1:0]    xCursor,
    input  logic [cursorWidth-1:0]    yCursor,
    input  logic                      blank,
    input  logic [15:0]               cellData,
    input  logic [7:0]                glyphData,
    output logic [cellAddrWidth-1:0]  cellReadAddr,
    output logic [glyphAddrWidth-1:0] glyphReadAddr,
    output logic [7:0]                attribute,
    output logic                      pixelOn,
    output logic                      pixelBlank
);

    // A character is 8 pixels wide and 16 rows high
    localparam int colBits    = 6;
    localparam int rowBits    = cellAddrWidth - colBits;
    localparam int codeBits   = glyphAddrWidth - 4;
    localparam int gridWidth  = 8 << colBits;
    localparam int gridHeight = 16 << rowBits;

    logic       outside;

    // Stage 1 side-band, in step with the cell read
    logic [3:0] glyphRow1;
    logic [2:0] pixelCol1;
    logic       blank1;

    // Stage 2 side-band, in step with the glyph read
    logic [7:0] attribute2;
    logic [2:0] pixelCol2;
    logic       blank2;

    assign outside = (xCursor >= gridWidth) || (yCursor >= gridHeight);

    // Character row then character column
    assign cellReadAddr = {yCursor[rowBits+3:4], xCursor[colBits+2:3]};

    // Code bit 7 is dropped, so codes 128 and up reuse the low glyphs
    assign glyphReadAddr = {cellData[codeBits-1:0], glyphRow1};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            blank1 <= 1'b1;  // Pipeline starts out blanked
            blank2 <= 1'b1;
        end else begin
            blank1 <= blank || outside;
            blank2 <= blank1;
        end
    end

    always_ff @(posedge clk) begin
        glyphRow1  <= yCursor[3:0];
        pixelCol1  <= xCursor[2:0];
        attribute2 <= cellData[15:8];  // Attribute arrives with the cell word
        pixelCol2  <= pixelCol1;
    end

    // Leftmost pixel of a glyph row is bit 7
    assign pixelOn    = glyphData[3'd7 - pixelCol2];
    assign attribute  = attribute2;
    assign pixelBlank = blank2;

endmodule

`default_nettype wire

// ==== textRender/dualPortRam.sv ====
`timescale 1ns/100ps
`default_nettype none

module dualPortRam #(
    parameter int dataWidth = 8,
    parameter int addrWidth = 11
) (
    input  logic                 clk,
    input  logic                 writeEnable,
    input  logic [addrWidth-1:0] writeAddr,
    input  logic [dataWidth-1:0] writeData,
    input  logic [addrWidth-1:0] readAddr,
    output logic [dataWidth-1:0] readData
);

    logic [dataWidth-1:0] mem [1 << addrWidth];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

    // Same-address read during a write returns the old word
    always_ff @(posedge clk) begin
        readData <= mem[readAddr];
    end

endmodule

`default_nettype wire

// ==== common/ppuPkg.sv ====
`default_nettype none

package ppuPkg;

    localparam int cellAddrWidth  = 11;  // 5 row bits, 6 column bits
    localparam int glyphAddrWidth = 11;  // 7 glyph bits, 4 row bits
    localparam int cursorWidth    = 10;  // One bit above the 512 grid

    localparam logic [15:0] cellRegionBase  = 16'h0000;
    localparam logic [15:0] glyphRegionBase = 16'h1000;
    localparam logic [15:0] controlAddr     = 16'h2000;

    typedef enum logic [1:0] {
        regionCell,
        regionGlyph,
        regionControl,
        regionNone
    } regionKind;

    typedef enum logic [3:0] {
        fgBlack, fgRed, fgGreen, fgMustard,
        fgBlue, fgViolet, fgCyan, fgDarkGray,
        fgLightGray, fgIntenseRed, fgIntenseGreen, fgIntenseYellow,
        fgIntenseBlue, fgIntenseMagenta, fgIntenseCyan, fgWhite
    } fgColor;

    // Entries packed as {red, green, blue}, 8 bits each
    localparam logic [23:0] fgPalette [16] = '{
        24'h000000, 24'h7F0000, 24'h007F00, 24'h7F7F00,
        24'h00007F, 24'h7F007F, 24'h007F7F, 24'h404040,
        24'h7F7F7F, 24'hFF0000, 24'h00FF00, 24'hFFFF00,
        24'h0000FF, 24'hFF00FF, 24'h00FFFF, 24'hFFFFFF
    };

    // Index bit 0 is red, bit 1 green, bit 2 blue
    localparam logic [23:0] bgPalette [8] = '{
        24'h000000, 24'hFF0000, 24'h00FF00, 24'hFFFF00,
        24'h0000FF, 24'hFF00FF, 24'h00FFFF, 24'hFFFFFF
    };

    localparam int pipeLatency = 3;  // Cursor in to RGB out

endpackage

`default_nettype wire
